//--- trellis_pkg.sv
`default_nettype none

package trellis_pkg;

   // ------------------------------------------------------------
   // code constants, K = 4, rate 1/2
   // ------------------------------------------------------------
   localparam int NUM_STATES  = 8;
   localparam int STATE_BITS  = 3;
   localparam int METRIC_BITS = 8;

   // tap vector is {new bit, s[0], s[1], s[2]}, newest tap in the MSB
   localparam logic [STATE_BITS:0] GEN_A = 4'b1101;   // 15 octal, symbol bit 1
   localparam logic [STATE_BITS:0] GEN_B = 4'b1111;   // 17 octal, symbol bit 0

   typedef logic [STATE_BITS-1:0]  state_t;     // newest input bit in the lsb
   typedef logic [1:0]             symbol_t;    // {gen_a out, gen_b out}
   typedef logic [METRIC_BITS-1:0] metric_t;
   typedef logic [NUM_STATES-1:0]  decision_t;  // one survivor bit per state

   // expected symbol for the transition out of old_state on new_bit
   function automatic symbol_t trans_symbol(state_t old_state, logic new_bit);
      logic [STATE_BITS:0] taps;
      taps = {new_bit, old_state[0], old_state[1], old_state[2]};
      return {^(taps & GEN_A), ^(taps & GEN_B)};
   endfunction

   // predecessor of s when the survivor bit is d
   // the dropped oldest bit comes back in at the top
   function automatic state_t prev_state(state_t s, logic d);
      return {d, s[STATE_BITS-1:1]};
   endfunction

endpackage

`default_nettype wire

//--- memory_pkg.sv
`default_nettype none

package memory_pkg;

   // ------------------------------------------------------------
   // survivor storage geometry
   // ------------------------------------------------------------
   localparam int NUM_BANKS = 4;    // one written, two read, one idle
   localparam int BLOCK_LEN = 32;   // words per bank, bits per decoded block

   localparam int ADDR_BITS = $clog2(BLOCK_LEN);
   localparam int BANK_BITS = $clog2(NUM_BANKS);

   typedef logic [ADDR_BITS-1:0] addr_t;   // address within one bank
   typedef logic [BANK_BITS-1:0] bank_t;   // bank index, wraps mod 4

endpackage

`default_nettype wire

//--- survivor_rd_if.sv
`timescale 1ns/10ps
`default_nettype none

interface survivor_rd_if import trellis_pkg::*, memory_pkg::*; ();
   logic      start;       // one cycle, begins a traceback turn
   decision_t conv_word;   // convergence bank word at step
   decision_t dec_word;    // decode bank word at step
   addr_t     step;        // shared read address

   modport mem (
      output start,
      output conv_word,
      output dec_word,
      input  step
   );

   modport tbu (
      input  start,
      input  conv_word,
      input  dec_word,
      output step
   );
endinterface

`default_nettype wire

//--- path_metric_unit.sv
`timescale 1ns/10ps
`default_nettype none

module path_metric_unit import trellis_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      enable_i,
   input  symbol_t   symbol_i,
   output decision_t decision_o,
   output logic      dec_valid_o
);

   metric_t                pm_q [NUM_STATES];
   metric_t                pm_nx [NUM_STATES];
   logic [NUM_STATES-1:0]  valid_q;
   logic [NUM_STATES-1:0]  valid_nx;
   logic [NUM_STATES-1:0]  msb;
   decision_t              dec_nx;
   decision_t              decision_q;
   logic                   dec_valid_q;
   logic                   norm;

   // hamming distance between two 2-bit symbols
   function automatic logic [1:0] sym_dist(symbol_t a, symbol_t b);
      symbol_t x;
      x = a ^ b;
      return {1'b0, x[1]} + {1'b0, x[0]};
   endfunction

   assign norm = &msb;   // every metric past half range

   // ------------------------------------------------------------
   // add-compare-select, one per next state
   // ------------------------------------------------------------
   for (genvar s = 0; s < NUM_STATES; s++) begin : g_acs
      state_t                ns;
      state_t                p0;
      state_t                p1;
      logic [1:0]            bm0;
      logic [1:0]            bm1;
      logic [METRIC_BITS:0]  c0;
      logic [METRIC_BITS:0]  c1;
      logic [METRIC_BITS:0]  sum;
      logic                  pick1;

      assign ns  = state_t'(s);
      assign p0  = prev_state(ns, 1'b0);
      assign p1  = prev_state(ns, 1'b1);
      assign bm0 = sym_dist(symbol_i, trans_symbol(p0, ns[0]));
      assign bm1 = sym_dist(symbol_i, trans_symbol(p1, ns[0]));

      assign c0 = {1'b0, pm_q[p0]} + {{(METRIC_BITS-1){1'b0}}, bm0};
      assign c1 = {1'b0, pm_q[p1]} + {{(METRIC_BITS-1){1'b0}}, bm1};

      // an unreached predecessor always loses, ties go to p0
      assign pick1 = valid_q[p1] && (!valid_q[p0] || (c1 < c0));
      assign sum   = pick1 ? c1 : c0;

      assign dec_nx[s]   = pick1;
      assign valid_nx[s] = valid_q[p0] | valid_q[p1];
      assign msb[s]      = pm_q[s][METRIC_BITS-1];
      assign pm_nx[s]    = norm ? {1'b0, sum[METRIC_BITS-2:0]} : sum[METRIC_BITS-1:0];

      // metric spread stays small, so a reached state never carries out
      a_no_wrap: assert property (@(posedge clk) disable iff (!rst)
         enable_i && valid_nx[s] |-> !sum[METRIC_BITS]);
   end

   // ------------------------------------------------------------
   // metric and validity registers
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pm_q        <= '{default: '0};
         valid_q     <= NUM_STATES'(1);   // only state 0 reached
         dec_valid_q <= 1'b0;
      end else if (!enable_i) begin
         pm_q        <= '{default: '0};
         valid_q     <= NUM_STATES'(1);
         dec_valid_q <= 1'b0;
      end else begin
         pm_q        <= pm_nx;
         valid_q     <= valid_nx;
         dec_valid_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (enable_i)
         decision_q <= dec_nx;
   end

   assign decision_o  = decision_q;
   assign dec_valid_o = dec_valid_q;

endmodule

`default_nettype wire

//--- survivor_memory.sv
`timescale 1ns/10ps
`default_nettype none

module survivor_memory import trellis_pkg::*, memory_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       enable_i,
   input  decision_t  decision_i,
   input  logic       dec_valid_i,
   survivor_rd_if.mem rd0,
   survivor_rd_if.mem rd1
);

   decision_t  mem_q [NUM_BANKS][BLOCK_LEN];
   addr_t      wr_addr_q;
   bank_t      wr_bank_q;
   logic       have_prev_q;          // first block already stored
   logic       next_unit_q;          // unit that gets the next start
   logic [1:0] start_q;
   logic [1:0] armed_q;              // unit holds a latched bank pair
   bank_t      conv_bank_q [2];
   bank_t      dec_bank_q [2];
   logic       blk_done;

   assign blk_done = dec_valid_i && (wr_addr_q == addr_t'(BLOCK_LEN-1));

   // ------------------------------------------------------------
   // decision storage, one word per symbol
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (dec_valid_i)
         mem_q[wr_bank_q][wr_addr_q] <= decision_i;
   end

   // ------------------------------------------------------------
   // write pointer, bank rotation and start scheduling
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_addr_q   <= '0;
         wr_bank_q   <= '0;
         have_prev_q <= 1'b0;
         next_unit_q <= 1'b0;
         start_q     <= '0;
         armed_q     <= '0;
         conv_bank_q <= '{default: '0};
         dec_bank_q  <= '{default: '0};
      end else if (!enable_i) begin
         wr_addr_q   <= '0;
         wr_bank_q   <= '0;           // rotation restarts at bank 0
         have_prev_q <= 1'b0;
         next_unit_q <= 1'b0;
         start_q     <= '0;
         armed_q     <= '0;
      end else begin
         start_q <= '0;
         if (dec_valid_i)
            wr_addr_q <= wr_addr_q + 1'b1;   // wraps at BLOCK_LEN
         if (blk_done) begin
            wr_bank_q   <= wr_bank_q + 1'b1;
            have_prev_q <= 1'b1;
            if (have_prev_q) begin
               start_q[next_unit_q]     <= 1'b1;
               armed_q[next_unit_q]     <= 1'b1;
               conv_bank_q[next_unit_q] <= wr_bank_q;          // block just done
               dec_bank_q[next_unit_q]  <= wr_bank_q - 1'b1;   // block before it
               next_unit_q              <= ~next_unit_q;
            end
         end
      end
   end

   // combinational reads for both traceback units
   assign rd0.start     = start_q[0];
   assign rd0.conv_word = mem_q[conv_bank_q[0]][rd0.step];
   assign rd0.dec_word  = mem_q[dec_bank_q[0]][rd0.step];

   assign rd1.start     = start_q[1];
   assign rd1.conv_word = mem_q[conv_bank_q[1]][rd1.step];
   assign rd1.dec_word  = mem_q[dec_bank_q[1]][rd1.step];

   // writer never lands in a bank a traceback unit is reading
   for (genvar u = 0; u < 2; u++) begin : g_chk
      a_bank_free: assert property (@(posedge clk) disable iff (!rst)
         armed_q[u] |-> (wr_bank_q != conv_bank_q[u]) && (wr_bank_q != dec_bank_q[u]));
   end

endmodule

`default_nettype wire

//--- traceback_unit.sv
`timescale 1ns/10ps
`default_nettype none

module traceback_unit import trellis_pkg::*, memory_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       enable_i,
   survivor_rd_if.tbu rd,
   output logic       bit_o,
   output logic       bit_valid_o,
   output logic       block_end_o
);

   state_t    state_q;
   addr_t     step_q;
   logic      active_q;
   logic      decode_q;    // 0 convergence pass, 1 decode pass
   decision_t word;

   assign rd.step = step_q;
   assign word    = decode_q ? rd.dec_word : rd.conv_word;

   // ------------------------------------------------------------
   // one trellis step back per cycle, 2 x BLOCK_LEN steps a turn
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q  <= '0;
         step_q   <= '0;
         active_q <= 1'b0;
         decode_q <= 1'b0;
      end else if (!enable_i) begin
         state_q  <= '0;
         step_q   <= '0;
         active_q <= 1'b0;
         decode_q <= 1'b0;
      end else if (rd.start) begin
         // a new turn may land on the last step of the previous one
         state_q  <= '0;              // arbitrary start, converges
         step_q   <= addr_t'(BLOCK_LEN-1);
         active_q <= 1'b1;
         decode_q <= 1'b0;
      end else if (active_q) begin
         state_q <= prev_state(state_q, word[state_q]);
         step_q  <= step_q - 1'b1;
         if (step_q == '0) begin
            decode_q <= ~decode_q;
            if (decode_q)
               active_q <= 1'b0;    // both passes done
         end
      end
   end

   // bits leave newest first, lsb of the state is the input bit
   assign bit_o       = state_q[0];
   assign bit_valid_o = active_q & decode_q;
   assign block_end_o = bit_valid_o & (step_q == '0);

endmodule

`default_nettype wire

//--- bit_reorder.sv
`timescale 1ns/10ps
`default_nettype none

module bit_reorder import memory_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic enable_i,
   input  logic bit0_i,
   input  logic bit_valid0_i,
   input  logic block_end0_i,
   input  logic bit1_i,
   input  logic bit_valid1_i,
   input  logic block_end1_i,
   output logic d_out_o,
   output logic d_valid_o
);

   logic [1:0] bit_in;
   logic [1:0] bit_vld;
   logic [1:0] blk_end;
   logic [1:0] rd_bits;      // buffer bit at rd_idx_q, per unit
   addr_t      rd_idx_q;
   logic       rd_active_q;
   logic       rd_sel_q;
   logic       d_out_q;
   logic       d_valid_q;

   assign bit_in  = {bit1_i, bit0_i};
   assign bit_vld = {bit_valid1_i, bit_valid0_i};
   assign blk_end = {block_end1_i, block_end0_i};

   // ------------------------------------------------------------
   // reversal buffers, filled from the top down
   // ------------------------------------------------------------
   for (genvar u = 0; u < 2; u++) begin : g_rev
      logic [BLOCK_LEN-1:0] rev_q;
      addr_t                wr_idx_q;

      always_ff @(posedge clk) begin
         if (bit_vld[u])
            rev_q[wr_idx_q] <= bit_in[u];
      end

      always_ff @(posedge clk or negedge rst) begin
         if (!rst)
            wr_idx_q <= addr_t'(BLOCK_LEN-1);
         else if (!enable_i)
            wr_idx_q <= addr_t'(BLOCK_LEN-1);
         else if (bit_vld[u])
            wr_idx_q <= wr_idx_q - 1'b1;   // newest bit goes highest
      end

      assign rd_bits[u] = rev_q[rd_idx_q];
   end

   // ------------------------------------------------------------
   // forward read and merged output
   // ------------------------------------------------------------
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         rd_active_q <= 1'b0;
         rd_sel_q    <= 1'b0;
         rd_idx_q    <= '0;
         d_out_q     <= 1'b0;
         d_valid_q   <= 1'b0;
      end else if (!enable_i) begin
         rd_active_q <= 1'b0;
         rd_sel_q    <= 1'b0;
         rd_idx_q    <= '0;
         d_out_q     <= 1'b0;
         d_valid_q   <= 1'b0;
      end else begin
         d_valid_q <= rd_active_q;
         d_out_q   <= rd_active_q & rd_bits[rd_sel_q];
         if (|blk_end) begin
            // other unit hands over right after our last read
            rd_active_q <= 1'b1;
            rd_sel_q    <= blk_end[1];
            rd_idx_q    <= '0;
         end else if (rd_active_q) begin
            rd_idx_q <= rd_idx_q + 1'b1;
            if (rd_idx_q == addr_t'(BLOCK_LEN-1))
               rd_active_q <= 1'b0;
         end
      end
   end

   assign d_out_o   = d_out_q;
   assign d_valid_o = d_valid_q;

   // the units decode one block apart, never in the same cycle
   a_one_writer: assert property (@(posedge clk) disable iff (!rst)
      !(bit_valid0_i && bit_valid1_i));

endmodule

`default_nettype wire

//--- viterbi_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module viterbi_decoder import trellis_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    enable_i,
   input  symbol_t d_in_i,
   output logic    d_out_o,
   output logic    d_valid_o
);

   decision_t decision;
   logic      dec_valid;
   logic      bit0;
   logic      bit_valid0;
   logic      block_end0;
   logic      bit1;
   logic      bit_valid1;
   logic      block_end1;

   survivor_rd_if rd0_if ();
   survivor_rd_if rd1_if ();

   // ------------------------------------------------------------
   // metrics -> survivors -> two tracebacks -> reorder
   // ------------------------------------------------------------
   path_metric_unit u_pmu (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .symbol_i    (d_in_i),
      .decision_o  (decision),
      .dec_valid_o (dec_valid)
   );

   survivor_memory u_smem (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .decision_i  (decision),
      .dec_valid_i (dec_valid),
      .rd0         (rd0_if.mem),
      .rd1         (rd1_if.mem)
   );

   traceback_unit tbu_0 (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .rd          (rd0_if.tbu),
      .bit_o       (bit0),
      .bit_valid_o (bit_valid0),
      .block_end_o (block_end0)
   );

   traceback_unit tbu_1 (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .rd          (rd1_if.tbu),
      .bit_o       (bit1),
      .bit_valid_o (bit_valid1),
      .block_end_o (block_end1)
   );

   bit_reorder u_reorder (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .bit0_i       (bit0),
      .bit_valid0_i (bit_valid0),
      .block_end0_i (block_end0),
      .bit1_i       (bit1),
      .bit_valid1_i (bit_valid1),
      .block_end1_i (block_end1),
      .d_out_o      (d_out_o),
      .d_valid_o    (d_valid_o)
   );

endmodule

`default_nettype wire

//--- tb_viterbi.sv
`timescale 1ns/10ps
`default_nettype none

module tb_viterbi import trellis_pkg::*, memory_pkg::*; ();

   localparam int CLK_PERIOD   = 100;
   localparam int CLEAN_BLOCKS = 10;
   localparam int NOISY_BLOCKS = 40;
   localparam int LEAD_BLOCKS  = 6;      // stream cut short by the restart
   localparam int NUM_TESTS    = 5;
   localparam int TOTAL_SYMS   = (3*CLEAN_BLOCKS + NOISY_BLOCKS + LEAD_BLOCKS) * BLOCK_LEN;
   localparam int CYCLE_LIMIT  = TOTAL_SYMS + NUM_TESTS*8*BLOCK_LEN;

   logic    clk = 1'b0;
   logic    rst;
   logic    enable_i;
   symbol_t d_in_i;
   logic    d_out_o;
   logic    d_valid_o;

   int         seed = 67;
   int         errors = 0;
   int         checks = 0;
   int         cycles = 0;
   logic [2:0] enc_state;    // encoder history, newest bit in the lsb
   logic       data_q [$];   // bits of the current stream
   logic       got_q [$];    // decoded bits in arrival order

   viterbi_decoder dut (
      .clk       (clk),
      .rst       (rst),
      .enable_i  (enable_i),
      .d_in_i    (d_in_i),
      .d_out_o   (d_out_o),
      .d_valid_o (d_valid_o)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   // outputs settle after the rising edge, so take them mid-cycle
   always @(negedge clk) begin
      if (d_valid_o)
         got_q.push_back(d_out_o);
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: no result after %0d cycles, errors so far %0d", cycles, errors);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // reference encoder and stimulus helpers
   // ------------------------------------------------------------
   // rate 1/2 encoder, generators 15 and 17 octal, input bit on the top tap
   function automatic symbol_t encode_symbol(logic [2:0] hist, logic b);
      logic [3:0] taps;
      taps = {b, hist[0], hist[1], hist[2]};
      return {^(taps & 4'o15), ^(taps & 4'o17)};
   endfunction

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic drive_bit(input logic b, input logic flip, input logic which);
      symbol_t sym;
      sym       = encode_symbol(enc_state, b);
      enc_state = {enc_state[1:0], b};
      if (flip)
         sym[which] = ~sym[which];   // channel error on one symbol bit
      @(posedge clk);
      enable_i <= 1'b1;
      d_in_i   <= sym;
   endtask

   task automatic new_stream(input int nbits);
      int r;
      int i;
      data_q.delete();
      enc_state = '0;   // decoder also starts in state 0
      for (i = 0; i < nbits; i++) begin
         r = $random(seed);
         data_q.push_back(r[0]);
      end
   endtask

   // err_period 0 sends a clean stream
   task automatic send_data(input int err_period);
      int   r;
      int   i;
      logic flip;
      for (i = 0; i < data_q.size(); i++) begin
         r    = $random(seed);
         flip = (err_period > 0) && ((i % err_period) == (err_period / 2));
         drive_bit(data_q[i], flip, r[0]);
      end
   endtask

   task automatic drop_enable();
      @(posedge clk);
      enable_i <= 1'b0;
      d_in_i   <= '0;
      repeat (3) @(posedge clk);
      got_q.delete();
   endtask

   // keep the trellis moving with zeros until the whole stream is out
   task automatic drain_and_compare(input string name);
      int n;
      int i;
      n = data_q.size();
      while (got_q.size() < n)
         drive_bit(1'b0, 1'b0, 1'b0);
      for (i = 0; i < n; i++)
         compare_value($sformatf("%s bit %0d", name, i), 32'(data_q[i]), 32'(got_q[i]));
      drop_enable();
   endtask

   // ------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------
   task automatic reset_quiet();
      int r;
      int i;
      for (i = 0; i < 10; i++) begin
         r = $random(seed);
         @(posedge clk);
         if (i == 2)
            rst <= 1'b1;        // held for two cycles
         d_in_i <= r[1:0];      // noise on the input, enable stays low
         @(negedge clk);
         compare_value("reset_quiet d_valid_o", 32'd0, 32'(d_valid_o));
         compare_value("reset_quiet d_out_o", 32'd0, 32'(d_out_o));
      end
   endtask

   task automatic clean_stream();
      new_stream(CLEAN_BLOCKS*BLOCK_LEN);
      send_data(0);
      drain_and_compare("clean_stream");
   endtask

   task automatic error_correction();
      new_stream(CLEAN_BLOCKS*BLOCK_LEN);
      send_data(12);
      drain_and_compare("error_correction");
   endtask

   // enough errors to push every metric past half range
   task automatic long_noisy_run();
      new_stream(NOISY_BLOCKS*BLOCK_LEN);
      send_data(8);
      drain_and_compare("long_noisy_run");
   endtask

   task automatic restart_stream();
      int i;
      new_stream(LEAD_BLOCKS*BLOCK_LEN);
      send_data(0);
      if (got_q.size() == 0) begin
         errors++;
         $display("restart_stream: no decoded bits came out before enable was dropped");
      end
      for (i = 0; i < got_q.size(); i++)
         compare_value($sformatf("restart_stream lead bit %0d", i), 32'(data_q[i]),
                       32'(got_q[i]));
      @(posedge clk);
      enable_i <= 1'b0;
      d_in_i   <= '0;
      repeat (2) begin
         @(posedge clk);
         @(negedge clk);
         compare_value("restart_stream d_valid_o", 32'd0, 32'(d_valid_o));
      end
      got_q.delete();
      new_stream(CLEAN_BLOCKS*BLOCK_LEN);   // enable returns with its first bit
      send_data(0);
      drain_and_compare("restart_stream");
   endtask

   initial begin
      rst      <= 1'b0;
      enable_i <= 1'b0;
      d_in_i   <= '0;
      reset_quiet();
      clean_stream();
      error_correction();
      long_noisy_run();
      restart_stream();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
trellis_pkg.sv
memory_pkg.sv
survivor_rd_if.sv
path_metric_unit.sv
survivor_memory.sv
traceback_unit.sv
bit_reorder.sv
viterbi_decoder.sv
tb_viterbi.sv

//--- run_sim.sh
#!/bin/sh
# build the viterbi testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
   --top-module tb_viterbi -f src.f -o tb_viterbi \
   && ./obj_dir/tb_viterbi > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log \
   && { echo "simulation failed"; exit 1; } \
   || echo "simulation passed"
exit 0
